/* Bender.yml */
package:
  name: vi_core

sources:
  - source/core_pkg.sv
  - source/int_alu.sv
  - source/mult_pipe.sv
  - source/fetch_unit.sv
  - source/decoder.sv
  - source/int_registers.sv
  - source/bypass_ctrl.sv
  - source/exec_stage.sv
  - source/vi_core.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_vi_core.sv

/* filelist.f */
+incdir+verification
source/core_pkg.sv
source/int_alu.sv
source/mult_pipe.sv
source/fetch_unit.sv
source/decoder.sv
source/int_registers.sv
source/bypass_ctrl.sv
source/exec_stage.sv
source/vi_core.sv
verification/tb_vi_core.sv

/* source/bypass_ctrl.sv */
// Operand forwarding for decode and the decode stall for multiply hazards
module bypass_ctrl
	import core_pkg::*;
(
	input  logic [REG_ADDR_W-1:0] rs1_i,
	input  logic [REG_ADDR_W-1:0] rs2_i,
	input  dec_ctrl_t             ctrl_i,
	input  logic [XLEN-1:0]       rdata1_i,
	input  logic [XLEN-1:0]       rdata2_i,
	input  wb_t                   exe_fwd_i,
	input  logic                  exe_is_mul_i,
	input  wb_t                   mult_stages_i [MULT_STAGES],
	input  wb_t                   wb_i,
	output logic [XLEN-1:0]       op_a_o,
	output logic [XLEN-1:0]       op_b_o,
	output logic                  stall_o
);

	logic raw_a;
	logic raw_b;
	logic mul_busy;

	function automatic logic [XLEN-1:0] fwd_pick(
		input logic [REG_ADDR_W-1:0] rs,
		input logic [XLEN-1:0] rf_data,
		input wb_t exe,
		input wb_t mul_last,
		input wb_t wb
	);
		logic [XLEN-1:0] res;
		res = rf_data;
		if (rs != '0) begin
			if (exe.valid && exe.rd == rs) begin
				res = exe.data;
			end else if (mul_last.valid && mul_last.rd == rs) begin
				res = mul_last.data;
			end else if (wb.valid && wb.rd == rs) begin
				res = wb.data;
			end
		end
		return res;
	endfunction

	assign op_a_o = fwd_pick(rs1_i, rdata1_i, exe_fwd_i, mult_stages_i[MULT_STAGES-1], wb_i);
	assign op_b_o = fwd_pick(rs2_i, rdata2_i, exe_fwd_i, mult_stages_i[MULT_STAGES-1], wb_i);

	// Products not yet in the last stage cannot be forwarded
	always_comb begin
		raw_a = exe_is_mul_i && (exe_fwd_i.rd == rs1_i);
		raw_b = exe_is_mul_i && (exe_fwd_i.rd == rs2_i);
		mul_busy = exe_is_mul_i;
		for (int i = 0; i < MULT_STAGES - 1; i++) begin
			if (mult_stages_i[i].valid) begin
				mul_busy = 1'b1;
				if (mult_stages_i[i].rd == rs1_i) begin
					raw_a = 1'b1;
				end
				if (mult_stages_i[i].rd == rs2_i) begin
					raw_b = 1'b1;
				end
			end
		end
		if (rs1_i == '0) begin
			raw_a = 1'b0;
		end
		if (rs2_i == '0) begin
			raw_b = 1'b0;
		end
	end

	// Non-MUL writers wait for older multiplies so writes retire in order
	assign stall_o = raw_a | raw_b | (ctrl_i.we & ~ctrl_i.is_mul & mul_busy);

endmodule

/* source/core_pkg.sv */
// Shared widths, opcodes, instruction views and pipeline bundles; imported by every core RTL file
package core_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS = 32;
	localparam int MULT_STAGES = 5;

	localparam logic [XLEN-1:0] RESET_PC = '0;
	// addi x0, x0, 0
	localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] FUNCT7_MUL = 7'b0000001;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS_B,
		ALU_EQ,
		ALU_NE
	} alu_op_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0] rd;
		logic [6:0] opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_u;

	typedef struct packed {
		alu_op_e alu_op;
		logic imm_sel;
		logic [XLEN-1:0] imm;
		logic [REG_ADDR_W-1:0] rd;
		logic we;
		logic is_mul;
		logic is_branch;
		logic is_jal;
	} dec_ctrl_t;

	typedef struct packed {
		logic valid;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0] data;
	} wb_t;

	typedef struct packed {
		logic valid;
		logic [XLEN-1:0] pc;
		instr_u instr;
	} fd_t;

endpackage

/* source/decoder.sv */
// Combinational decode of one instruction word into register addresses and control fields
module decoder
	import core_pkg::*;
(
	input  instr_u                 instr_i,
	output logic [REG_ADDR_W-1:0] rs1_o,
	output logic [REG_ADDR_W-1:0] rs2_o,
	output dec_ctrl_t              ctrl_o
);

	always_comb begin
		ctrl_o = '0;
		rs1_o = '0;
		rs2_o = '0;
		case (instr_i.r.opcode)
			OPC_OP: begin
				rs1_o = instr_i.r.rs1;
				rs2_o = instr_i.r.rs2;
				ctrl_o.rd = instr_i.r.rd;
				ctrl_o.we = 1'b1;
				if (instr_i.r.funct7 == FUNCT7_MUL) begin
					ctrl_o.is_mul = (instr_i.r.funct3 == 3'b000);
					ctrl_o.we = (instr_i.r.funct3 == 3'b000);
				end else begin
					case (instr_i.r.funct3)
						3'b000: ctrl_o.alu_op = instr_i.r.funct7[5] ? ALU_SUB : ALU_ADD;
						3'b001: ctrl_o.alu_op = ALU_SLL;
						3'b010: ctrl_o.alu_op = ALU_SLT;
						3'b100: ctrl_o.alu_op = ALU_XOR;
						3'b101: ctrl_o.alu_op = ALU_SRL;
						3'b110: ctrl_o.alu_op = ALU_OR;
						3'b111: ctrl_o.alu_op = ALU_AND;
						default: ctrl_o.we = 1'b0;
					endcase
				end
			end
			OPC_OP_IMM: begin
				rs1_o = instr_i.i.rs1;
				ctrl_o.rd = instr_i.i.rd;
				ctrl_o.imm_sel = 1'b1;
				ctrl_o.imm = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
				ctrl_o.we = 1'b1;
				case (instr_i.i.funct3)
					3'b000: ctrl_o.alu_op = ALU_ADD;
					3'b010: ctrl_o.alu_op = ALU_SLT;
					3'b100: ctrl_o.alu_op = ALU_XOR;
					3'b110: ctrl_o.alu_op = ALU_OR;
					3'b111: ctrl_o.alu_op = ALU_AND;
					default: ctrl_o.we = 1'b0;
				endcase
			end
			OPC_LUI: begin
				ctrl_o.rd = instr_i.u.rd;
				ctrl_o.imm_sel = 1'b1;
				ctrl_o.imm = {instr_i.u.imm, 12'b0};
				ctrl_o.alu_op = ALU_PASS_B;
				ctrl_o.we = 1'b1;
			end
			OPC_BRANCH: begin
				rs1_o = instr_i.b.rs1;
				rs2_o = instr_i.b.rs2;
				ctrl_o.imm = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
					instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
				ctrl_o.is_branch = (instr_i.b.funct3 == 3'b000) || (instr_i.b.funct3 == 3'b001);
				ctrl_o.alu_op = instr_i.b.funct3[0] ? ALU_NE : ALU_EQ;
			end
			OPC_JAL: begin
				ctrl_o.rd = instr_i.j.rd;
				ctrl_o.imm = {{11{instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
					instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};
				ctrl_o.is_jal = 1'b1;
				ctrl_o.we = 1'b1;
			end
			default: begin
			end
		endcase
		// Writes to x0 never leave decode
		if (ctrl_o.rd == '0) begin
			ctrl_o.we = 1'b0;
		end
	end

endmodule

/* source/exec_stage.sv */
// Execute stage: decode-to-execute latch, ALU and branch resolution, multiply pipe, writeback latch
module exec_stage
	import core_pkg::*;
(
	input  logic            clk_i,
	input  logic            rst_i,
	input  logic            stall_i,
	input  fd_t             fd_i,
	input  dec_ctrl_t       ctrl_i,
	input  logic [XLEN-1:0] op_a_i,
	input  logic [XLEN-1:0] op_b_i,
	output logic            redirect_o,
	output logic [XLEN-1:0] redirect_pc_o,
	output wb_t             exe_fwd_o,
	output logic            exe_is_mul_o,
	output wb_t             mult_stages_o [MULT_STAGES],
	output wb_t             wb_o
);

	logic de_valid_q;
	logic [XLEN-1:0] de_pc_q;
	logic [XLEN-1:0] de_a_q;
	logic [XLEN-1:0] de_b_q;
	dec_ctrl_t de_ctrl_q;
	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] alu_res;
	logic [XLEN-1:0] exe_data;
	wb_t mul_start;
	wb_t wb_q;

	// Bubble on stall, and kill the decode slot on a taken branch or JAL
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			de_valid_q <= 1'b0;
		end else begin
			de_valid_q <= fd_i.valid & ~stall_i & ~redirect_o;
		end
	end

	always_ff @(posedge clk_i) begin
		de_pc_q <= fd_i.pc;
		de_ctrl_q <= ctrl_i;
		de_a_q <= op_a_i;
		de_b_q <= op_b_i;
	end

	assign alu_b = de_ctrl_q.imm_sel ? de_ctrl_q.imm : de_b_q;

	int_alu int_alu(
		.op_i     (de_ctrl_q.alu_op),
		.a_i      (de_a_q),
		.b_i      (alu_b),
		.result_o (alu_res)
	);

	assign redirect_o = de_valid_q & (de_ctrl_q.is_jal | (de_ctrl_q.is_branch & alu_res[0]));
	assign redirect_pc_o = de_pc_q + de_ctrl_q.imm;

	// JAL links pc+4
	assign exe_data = de_ctrl_q.is_jal ? de_pc_q + XLEN'(4) : alu_res;

	assign exe_fwd_o = '{
		valid: de_valid_q & de_ctrl_q.we & ~de_ctrl_q.is_mul,
		rd: de_ctrl_q.rd,
		data: exe_data
	};
	assign exe_is_mul_o = de_valid_q & de_ctrl_q.we & de_ctrl_q.is_mul;
	assign mul_start = '{valid: exe_is_mul_o, rd: de_ctrl_q.rd, data: '0};

	mult_pipe mult_pipe(
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.start_i  (mul_start),
		.a_i      (de_a_q),
		.b_i      (de_b_q),
		.stages_o (mult_stages_o)
	);

	// Decode stall keeps the multiply and ALU writes from meeting here
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wb_q <= '0;
		end else if (mult_stages_o[MULT_STAGES-1].valid) begin
			wb_q <= mult_stages_o[MULT_STAGES-1];
		end else begin
			wb_q <= exe_fwd_o;
		end
	end

	assign wb_o = wb_q;

endmodule

/* source/fetch_unit.sv */
// Instruction fetch: PC, one-outstanding memory handshake and the fetch-to-decode latch
module fetch_unit
	import core_pkg::*;
(
	input  logic            clk_i,
	input  logic            rst_i,
	input  logic            stall_i,
	input  logic            redirect_i,
	input  logic [XLEN-1:0] redirect_pc_i,
	input  logic            instr_ready_i,
	input  logic [XLEN-1:0] instr_data_i,
	output logic            instr_req_o,
	output logic [XLEN-1:0] instr_addr_o,
	output fd_t             fd_o
);

	logic req_q;
	logic discard_q;
	logic [XLEN-1:0] addr_q;
	logic [XLEN-1:0] target_q;
	logic done;
	logic accept;
	fd_t fd_q;

	assign done = req_q & instr_ready_i;
	// A word arriving under stall is dropped and fetched again
	assign accept = done & ~discard_q & ~redirect_i & ~stall_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			req_q <= 1'b0;
			discard_q <= 1'b0;
			addr_q <= RESET_PC;
		end else begin
			req_q <= 1'b1;
			if (done) begin
				discard_q <= 1'b0;
				if (redirect_i) begin
					addr_q <= redirect_pc_i;
				end else if (discard_q) begin
					addr_q <= target_q;
				end else if (!stall_i) begin
					addr_q <= addr_q + XLEN'(4);
				end
			end else if (redirect_i) begin
				// Access in flight must finish before the target is requested
				if (req_q) begin
					discard_q <= 1'b1;
				end else begin
					addr_q <= redirect_pc_i;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (redirect_i) begin
			target_q <= redirect_pc_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i || redirect_i) begin
			fd_q <= {1'b0, {XLEN{1'b0}}, NOP_INSTR};
		end else if (accept) begin
			fd_q <= {1'b1, addr_q, instr_data_i};
		end else if (!stall_i) begin
			fd_q <= {1'b0, {XLEN{1'b0}}, NOP_INSTR};
		end
	end

	assign instr_req_o = req_q;
	assign instr_addr_o = addr_q;
	assign fd_o = fd_q;

endmodule

/* source/int_alu.sv */
// Combinational integer ALU; eq and ne return the compare result in bit 0
module int_alu
	import core_pkg::*;
(
	input  alu_op_e         op_i,
	input  logic [XLEN-1:0] a_i,
	input  logic [XLEN-1:0] b_i,
	output logic [XLEN-1:0] result_o
);

	logic lt;
	logic eq;

	assign lt = $signed(a_i) < $signed(b_i);
	assign eq = (a_i == b_i);

	always_comb begin
		case (op_i)
			ALU_ADD:    result_o = a_i + b_i;
			ALU_SUB:    result_o = a_i - b_i;
			ALU_AND:    result_o = a_i & b_i;
			ALU_OR:     result_o = a_i | b_i;
			ALU_XOR:    result_o = a_i ^ b_i;
			ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, lt};
			ALU_SLL:    result_o = a_i << b_i[4:0];
			ALU_SRL:    result_o = a_i >> b_i[4:0];
			ALU_PASS_B: result_o = b_i;
			ALU_EQ:     result_o = {{(XLEN-1){1'b0}}, eq};
			ALU_NE:     result_o = {{(XLEN-1){1'b0}}, ~eq};
			default:    result_o = '0;
		endcase
	end

endmodule

/* source/int_registers.sv */
// Integer register file: two asynchronous read ports, one synchronous write port, x0 reads zero
module int_registers
	import core_pkg::*;
(
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  logic [REG_ADDR_W-1:0] rs1_i,
	input  logic [REG_ADDR_W-1:0] rs2_i,
	input  wb_t                   wb_i,
	output logic [XLEN-1:0]       rdata1_o,
	output logic [XLEN-1:0]       rdata2_o
);

	logic [XLEN-1:0] regs_q [NUM_REGS];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wb_i.valid && wb_i.rd != '0) begin
			regs_q[wb_i.rd] <= wb_i.data;
		end
	end

	assign rdata1_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
	assign rdata2_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

/* source/mult_pipe.sv */
// Multiplier whose low product word travels a tagged delay line, last entry is the final stage
module mult_pipe
	import core_pkg::*;
(
	input  logic            clk_i,
	input  logic            rst_i,
	input  wb_t             start_i,
	input  logic [XLEN-1:0] a_i,
	input  logic [XLEN-1:0] b_i,
	output wb_t             stages_o [MULT_STAGES]
);

	wb_t stages_q [MULT_STAGES];
	logic [XLEN-1:0] product;

	// Low word only
	assign product = a_i * b_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < MULT_STAGES; i++) begin
				stages_q[i] <= '0;
			end
		end else begin
			stages_q[0] <= '{valid: start_i.valid, rd: start_i.rd, data: product};
			for (int i = 1; i < MULT_STAGES; i++) begin
				stages_q[i] <= stages_q[i-1];
			end
		end
	end

	assign stages_o = stages_q;

endmodule

/* source/vi_core.sv */
// Core top level: connects fetch, decode, register file, bypass and execute stages
module vi_core
	import core_pkg::*;
(
	input  logic            clk_i,
	input  logic            rst_i,
	input  logic            instr_ready_i,
	input  logic [XLEN-1:0] instr_data_i,
	output logic            instr_req_o,
	output logic [XLEN-1:0] instr_addr_o,
	output wb_t             wb_o
);

	fd_t fd;
	dec_ctrl_t ctrl;
	logic [REG_ADDR_W-1:0] rs1;
	logic [REG_ADDR_W-1:0] rs2;
	logic [XLEN-1:0] rdata1;
	logic [XLEN-1:0] rdata2;
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic stall;
	logic redirect;
	logic [XLEN-1:0] redirect_pc;
	wb_t exe_fwd;
	logic exe_is_mul;
	wb_t mult_stages [MULT_STAGES];

	fetch_unit fetch_unit(
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.stall_i       (stall),
		.redirect_i    (redirect),
		.redirect_pc_i (redirect_pc),
		.instr_ready_i (instr_ready_i),
		.instr_data_i  (instr_data_i),
		.instr_req_o   (instr_req_o),
		.instr_addr_o  (instr_addr_o),
		.fd_o          (fd)
	);

	decoder decoder(
		.instr_i (fd.instr),
		.rs1_o   (rs1),
		.rs2_o   (rs2),
		.ctrl_o  (ctrl)
	);

	int_registers int_registers(
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.rs1_i    (rs1),
		.rs2_i    (rs2),
		.wb_i     (wb_o),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2)
	);

	bypass_ctrl bypass_ctrl(
		.rs1_i         (rs1),
		.rs2_i         (rs2),
		.ctrl_i        (ctrl),
		.rdata1_i      (rdata1),
		.rdata2_i      (rdata2),
		.exe_fwd_i     (exe_fwd),
		.exe_is_mul_i  (exe_is_mul),
		.mult_stages_i (mult_stages),
		.wb_i          (wb_o),
		.op_a_o        (op_a),
		.op_b_o        (op_b),
		.stall_o       (stall)
	);

	exec_stage exec_stage(
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.stall_i       (stall),
		.fd_i          (fd),
		.ctrl_i        (ctrl),
		.op_a_i        (op_a),
		.op_b_i        (op_b),
		.redirect_o    (redirect),
		.redirect_pc_o (redirect_pc),
		.exe_fwd_o     (exe_fwd),
		.exe_is_mul_o  (exe_is_mul),
		.mult_stages_o (mult_stages),
		.wb_o          (wb_o)
	);

endmodule

/* verification/isa_model.svh */
// Instruction-set reference model and LFSR random source, included inside the testbench module
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

typedef enum logic [4:0] {
	K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_SLL, K_SRL, K_ADDI,
	K_ANDI, K_ORI, K_XORI, K_SLTI, K_LUI, K_BEQ, K_BNE, K_JAL, K_MUL
} kind_e;

localparam int PROG_LEN = 200;
localparam int NUM_KINDS = 18;

kind_e p_kind [PROG_LEN];
logic [2:0] p_rd [PROG_LEN];
logic [2:0] p_rs1 [PROG_LEN];
logic [2:0] p_rs2 [PROG_LEN];
// Sign-extended immediate, LUI value already shifted, byte offset for branches and JAL
logic [31:0] p_imm [PROG_LEN];
logic [31:0] p_word [PROG_LEN];
logic [31:0] model_regs [8];
wb_t expected [$];
logic [31:0] lfsr_state;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int k = 0; k < n; k++) begin
		lfsr_state = lfsr_next(lfsr_state);
		v = {v[30:0], lfsr_state[0]};
	end
	return v;
endfunction

// Executes the program in order and queues every write to a nonzero register
task automatic run_model();
	int pc;
	int next;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm;
	logic [31:0] res;
	logic wr;
	for (int r = 0; r < 8; r++) begin
		model_regs[r] = '0;
	end
	pc = 0;
	while (pc < PROG_LEN - 1) begin
		a = model_regs[p_rs1[pc]];
		b = model_regs[p_rs2[pc]];
		imm = p_imm[pc];
		wr = 1'b1;
		next = pc + 1;
		res = '0;
		case (p_kind[pc])
			K_ADD:  res = a + b;
			K_SUB:  res = a - b;
			K_AND:  res = a & b;
			K_OR:   res = a | b;
			K_XOR:  res = a ^ b;
			K_SLT:  res = {31'b0, $signed(a) < $signed(b)};
			K_SLL:  res = a << b[4:0];
			K_SRL:  res = a >> b[4:0];
			K_ADDI: res = a + imm;
			K_ANDI: res = a & imm;
			K_ORI:  res = a | imm;
			K_XORI: res = a ^ imm;
			K_SLTI: res = {31'b0, $signed(a) < $signed(imm)};
			K_LUI:  res = imm;
			K_MUL:  res = a * b;
			K_JAL: begin
				res = 32'(pc * 4 + 4);
				next = pc + int'(imm >> 2);
			end
			default: begin
				wr = 1'b0;
				if ((a == b) == (p_kind[pc] == K_BEQ)) begin
					next = pc + int'(imm >> 2);
				end
			end
		endcase
		if (wr && p_rd[pc] != 3'd0) begin
			model_regs[p_rd[pc]] = res;
			expected.push_back('{valid: 1'b1, rd: {2'b00, p_rd[pc]}, data: res});
		end
		pc = next;
	end
endtask

`endif

/* verification/tb_vi_core.sv */
// Testbench top for vi_core that runs a random program from a slow fetch memory and checks retired writes against the model
module tb_vi_core
	import core_pkg::*;
();

	logic clk;
	logic rst;
	logic instr_ready;
	logic [XLEN-1:0] instr_data;
	logic instr_req;
	logic [XLEN-1:0] instr_addr;
	wb_t retire;

	int fetches;
	int checked;
	int expected_total;
	int mem_wait;
	logic mem_busy;
	logic seen_req;

	`include "isa_model.svh"

	vi_core dut0(
		.clk_i         (clk),
		.rst_i         (rst),
		.instr_ready_i (instr_ready),
		.instr_data_i  (instr_data),
		.instr_req_o   (instr_req),
		.instr_addr_o  (instr_addr),
		.wb_o          (retire)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] encode(input int n);
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [31:0] imm;
		logic [31:0] w;
		rd = {2'b00, p_rd[n]};
		rs1 = {2'b00, p_rs1[n]};
		rs2 = {2'b00, p_rs2[n]};
		imm = p_imm[n];
		case (p_kind[n])
			K_ADD:  w = {7'b0000000, rs2, rs1, 3'b000, rd, OPC_OP};
			K_SUB:  w = {7'b0100000, rs2, rs1, 3'b000, rd, OPC_OP};
			K_AND:  w = {7'b0000000, rs2, rs1, 3'b111, rd, OPC_OP};
			K_OR:   w = {7'b0000000, rs2, rs1, 3'b110, rd, OPC_OP};
			K_XOR:  w = {7'b0000000, rs2, rs1, 3'b100, rd, OPC_OP};
			K_SLT:  w = {7'b0000000, rs2, rs1, 3'b010, rd, OPC_OP};
			K_SLL:  w = {7'b0000000, rs2, rs1, 3'b001, rd, OPC_OP};
			K_SRL:  w = {7'b0000000, rs2, rs1, 3'b101, rd, OPC_OP};
			K_MUL:  w = {FUNCT7_MUL, rs2, rs1, 3'b000, rd, OPC_OP};
			K_ADDI: w = {imm[11:0], rs1, 3'b000, rd, OPC_OP_IMM};
			K_ANDI: w = {imm[11:0], rs1, 3'b111, rd, OPC_OP_IMM};
			K_ORI:  w = {imm[11:0], rs1, 3'b110, rd, OPC_OP_IMM};
			K_XORI: w = {imm[11:0], rs1, 3'b100, rd, OPC_OP_IMM};
			K_SLTI: w = {imm[11:0], rs1, 3'b010, rd, OPC_OP_IMM};
			K_LUI:  w = {imm[31:12], rd, OPC_LUI};
			K_BEQ:  w = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
			K_BNE:  w = {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], OPC_BRANCH};
			default: w = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
		endcase
		return w;
	endfunction

	// Forward-only control flow ending in a JAL to itself
	task automatic build_program();
		logic [31:0] sel;
		logic [31:0] off;
		logic [31:0] lui_imm;
		logic [11:0] imm12;
		int remain;
		for (int n = 0; n < PROG_LEN - 1; n++) begin
			sel = rand_bits(5) % NUM_KINDS;
			p_kind[n] = kind_e'(sel[4:0]);
			p_rd[n] = 3'(rand_bits(3));
			p_rs1[n] = 3'(rand_bits(3));
			p_rs2[n] = 3'(rand_bits(3));
			imm12 = 12'(rand_bits(12));
			p_imm[n] = {{20{imm12[11]}}, imm12};
			remain = PROG_LEN - 1 - n;
			if (p_kind[n] == K_LUI) begin
				lui_imm = rand_bits(20);
				p_imm[n] = {lui_imm[19:0], 12'b0};
			end else if (p_kind[n] inside {K_BEQ, K_BNE, K_JAL}) begin
				off = 1 + rand_bits(2);
				if (off > remain) begin
					off = remain;
				end
				p_imm[n] = off * 4;
			end
			p_word[n] = encode(n);
		end
		p_kind[PROG_LEN-1] = K_JAL;
		p_rd[PROG_LEN-1] = 3'd0;
		p_imm[PROG_LEN-1] = '0;
		p_word[PROG_LEN-1] = encode(PROG_LEN - 1);
	endtask

	function automatic logic [31:0] fetch_word(input logic [XLEN-1:0] addr);
		if ((addr >> 2) < PROG_LEN) begin
			return p_word[addr >> 2];
		end
		return NOP_INSTR;
	endfunction

	task automatic stop_failed();
		$display("Regression failed");
		$fatal(1, "Stopping at the first error");
	endtask

	// A high ready seen here was accepted on the last rising edge
	task automatic drive_memory();
		if (instr_ready) begin
			instr_ready = 1'b0;
			mem_busy = 1'b0;
			fetches++;
		end
		if (instr_req && !mem_busy) begin
			mem_busy = 1'b1;
			mem_wait = rand_bits(2);
		end
		if (mem_busy) begin
			if (mem_wait == 0) begin
				instr_ready = 1'b1;
				instr_data = fetch_word(instr_addr);
			end else begin
				mem_wait--;
			end
		end
	endtask

	task automatic check_first_request();
		if (instr_req && !seen_req) begin
			seen_req = 1'b1;
			assert (instr_addr == RESET_PC) else begin
				$display("** Error: instr_addr_o=%h expected %h", instr_addr, RESET_PC);
				stop_failed();
			end
		end
	endtask

	task automatic check_retire();
		wb_t head;
		if (retire.valid) begin
			assert (fetches != 0) else begin
				$display("Error: a register write retired before any instruction was fetched");
				stop_failed();
			end
			assert (expected.size() != 0) else begin
				$display("Error: a register write retired after every expected write was seen");
				stop_failed();
			end
			head = expected.pop_front();
			assert (retire.rd == head.rd && retire.data == head.data) else begin
				$display("** Error: wb_o.rd=%h wb_o.data=%h expected rd=%h data=%h",
					retire.rd, retire.data, head.rd, head.data);
				stop_failed();
			end
			checked++;
		end
	endtask

	task automatic step_cycle();
		check_first_request();
		check_retire();
		drive_memory();
	endtask

	initial begin
		rst = 1'b1;
		instr_ready = 1'b0;
		instr_data = NOP_INSTR;
		fetches = 0;
		checked = 0;
		mem_wait = 0;
		mem_busy = 1'b0;
		seen_req = 1'b0;
		lfsr_state = 32'h26fb5f10;
		build_program();
		run_model();
		expected_total = expected.size();
		repeat (3) begin
			@(negedge clk);
			assert (!instr_req && !retire.valid) else begin
				$display("Error: fetch request or retire write seen during reset");
				stop_failed();
			end
		end
		rst = 1'b0;
		while (checked < expected_total) begin
			@(negedge clk);
			step_cycle();
		end
		// Let the self loop run so stray writes would show up
		repeat (20) begin
			@(negedge clk);
			step_cycle();
		end
		$display("Regression passed");
		$finish;
	end

	initial begin
		repeat (PROG_LEN * 40) @(posedge clk);
		$display("Error: watchdog expired with %0d expected writes not retired", expected.size());
		stop_failed();
	end

endmodule
